// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN  = 32;
	localparam int OPC_W = 10;

	// bit positions in the one-hot opcode_type word
	localparam int INST_LUI   = 0;
	localparam int INST_AUIPC = 1;
	localparam int INST_JAL   = 2;
	localparam int INST_JALR  = 3;
	localparam int INST_BEQ   = 4; // all branches
	localparam int INST_LW    = 5;
	localparam int INST_SW    = 6;
	localparam int INST_ADDI  = 7; // reg-imm alu
	localparam int INST_ADD   = 8; // reg-reg alu
	localparam int INST_CSR   = 9;

	localparam logic [2:0] F3_CSRRW = 3'd1;
	localparam logic [2:0] F3_CSRRS = 3'd2;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 32'd11;

	// immediate word, also read as a csr address for csr instructions
	typedef union packed {
		logic [XLEN-1:0] word;
		struct packed {
			logic [19:0] upper;
			logic [11:0] csr_addr;
		} csr;
	} imm_word_u;

endpackage

`default_nettype wire

// File: design/exu_op_pkg.sv
`default_nettype none

package exu_op_pkg;

	localparam int ALU_OP_W = 4;

	// internal alu operations
	localparam logic [ALU_OP_W-1:0] OP_ADD   = 4'd0;
	localparam logic [ALU_OP_W-1:0] OP_SUB   = 4'd1;
	localparam logic [ALU_OP_W-1:0] OP_AND   = 4'd2;
	localparam logic [ALU_OP_W-1:0] OP_XOR   = 4'd3;
	localparam logic [ALU_OP_W-1:0] OP_OR    = 4'd4;
	localparam logic [ALU_OP_W-1:0] OP_SRL   = 4'd5;
	localparam logic [ALU_OP_W-1:0] OP_SRA   = 4'd6;
	localparam logic [ALU_OP_W-1:0] OP_SLL   = 4'd7;
	localparam logic [ALU_OP_W-1:0] OP_LESS  = 4'd8; // signed slt
	localparam logic [ALU_OP_W-1:0] OP_ULESS = 4'd9; // unsigned sltu

endpackage

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu
	import exu_op_pkg::*;
(
	input  logic [31:0]         loperand,
	input  logic [31:0]         roperand,
	input  logic [ALU_OP_W-1:0] alu_op,
	output logic [31:0]         alu_val
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        borrow;
	logic        less;
	logic [4:0]  shamt;

	assign sum = loperand + roperand;

	// one subtractor for sub, slt and sltu
	assign {borrow, diff} = {1'b0, loperand} - {1'b0, roperand};

	// sign differs: left negative wins, else look at diff sign
	assign less = (loperand[31] & ~roperand[31]) |
		(~(loperand[31] ^ roperand[31]) & diff[31]);

	assign shamt = roperand[4:0];

	always_comb begin
		case (alu_op)
			OP_ADD:   alu_val = sum;
			OP_SUB:   alu_val = diff;
			OP_AND:   alu_val = loperand & roperand;
			OP_XOR:   alu_val = loperand ^ roperand;
			OP_OR:    alu_val = loperand | roperand;
			OP_SRL:   alu_val = loperand >> shamt;
			OP_SRA:   alu_val = $unsigned($signed(loperand) >>> shamt);
			OP_SLL:   alu_val = loperand << shamt;
			OP_LESS:  alu_val = {31'b0, less};
			OP_ULESS: alu_val = {31'b0, borrow}; // borrow out means l < r unsigned
			default:  alu_val = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/branch_cmp.sv
`default_nettype none

module branch_cmp
	import rv_isa_pkg::*;
(
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [2:0]      funct3,
	output logic            branch_taken
);

	logic [XLEN-1:0] diff;
	logic            borrow;
	logic            equal;
	logic            less;
	logic            uless;

	assign {borrow, diff} = {1'b0, src1} - {1'b0, src2};
	assign equal = ~|diff;
	assign less  = (src1[XLEN-1] & ~src2[XLEN-1]) |
		(~(src1[XLEN-1] ^ src2[XLEN-1]) & diff[XLEN-1]);
	assign uless = borrow;

	always_comb begin
		case (funct3)
			3'b000:  branch_taken = equal;  // beq
			3'b001:  branch_taken = ~equal; // bne
			3'b100:  branch_taken = less;
			3'b101:  branch_taken = ~less;
			3'b110:  branch_taken = uless;
			3'b111:  branch_taken = ~uless; // bgeu
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/exu_stage.sv
`default_nettype none

module exu_stage
	import rv_isa_pkg::*;
	import exu_op_pkg::*;
(
	input  logic            clock,
	input  logic            rst_n,

	input  logic            exu_valid,
	output logic            exu_ready,
	output logic            lsu_valid,
	input  logic            lsu_ready,

	input  logic [OPC_W-1:0] opcode_type,
	input  logic [3:0]      rd_in,
	input  logic [XLEN-1:0] src1_in,
	input  logic [XLEN-1:0] src2_in,
	input  logic [XLEN-1:0] imm_in,
	input  logic [2:0]      funct3_in,
	input  logic            funct7_5_in,
	input  logic [XLEN-1:0] pc_in,
	input  logic            reg_wen_in,
	input  logic            inst_ecall_in,
	input  logic            inst_mret_in,

	output logic [XLEN-1:0] pc,
	output logic [3:0]      rd,
	output logic [2:0]      funct3,
	output logic            reg_wen,
	output logic            inst_ecall,
	output logic            inst_mret,
	output logic            exu_complete,
	output logic            jump_wrong,
	output logic [XLEN-1:0] val,
	output logic [XLEN-1:0] lsu_data,
	output logic [XLEN-1:0] jump_addr,
	output logic [XLEN-1:0] csr_wdata,
	output logic [11:0]     csr_imm,
	output logic            lsu_ren,
	output logic            lsu_wen,
	output logic            csr_enable,

	input  logic [XLEN-1:0] csr_val,
	input  logic [XLEN-1:0] csr_jump,
	input  logic            csr_jump_en
);

	logic [OPC_W-1:0]    opc;
	logic [XLEN-1:0]     src1;
	logic [XLEN-1:0]     src2;
	imm_word_u           imm;
	logic                funct7_5;
	logic                ready_q;
	logic                accept;
	logic [XLEN-1:0]     snpc;
	logic [XLEN-1:0]     loperand;
	logic [XLEN-1:0]     roperand;
	logic [ALU_OP_W-1:0] alu_op;
	logic [XLEN-1:0]     alu_val;
	logic                branch_taken;
	logic                jump_en;
	logic                alu_class;

	assign accept    = exu_valid & exu_ready;
	assign exu_ready = ready_q & ~jump_wrong; // hold off fetch during redirect

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ready_q      <= 1'b1;
			lsu_valid    <= 1'b0;
			exu_complete <= 1'b0;
			jump_wrong   <= 1'b0;
		end else begin
			ready_q      <= (ready_q & ~accept) | (~ready_q & lsu_valid & lsu_ready);
			lsu_valid    <= (lsu_valid & ~lsu_ready) | (~lsu_valid & accept);
			exu_complete <= accept;
			jump_wrong   <= exu_complete & (jump_addr != snpc);
		end
	end

	// decode control
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			opc        <= '0;
			reg_wen    <= 1'b0;
			inst_ecall <= 1'b0;
			inst_mret  <= 1'b0;
		end else if (accept) begin
			opc        <= opcode_type;
			reg_wen    <= reg_wen_in;
			inst_ecall <= inst_ecall_in;
			inst_mret  <= inst_mret_in;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd       <= rd_in;
			src1     <= src1_in;
			src2     <= src2_in;
			imm.word <= imm_in;
			funct3   <= funct3_in;
			funct7_5 <= funct7_5_in;
			pc       <= pc_in;
		end
	end

	assign snpc      = pc + 32'd4;
	assign alu_class = opc[INST_ADDI] | opc[INST_ADD];

	assign loperand = (opc[INST_AUIPC] | opc[INST_JAL] | opc[INST_BEQ]) ? pc :
		opc[INST_LUI] ? '0 : src1;
	assign roperand = opc[INST_ADD] ? src2 : imm.word;

	always_comb begin
		alu_op = OP_ADD; // address and target math
		if (alu_class) begin
			case (funct3)
				3'b000: alu_op = (opc[INST_ADD] & funct7_5) ? OP_SUB : OP_ADD;
				3'b001: alu_op = OP_SLL;
				3'b010: alu_op = OP_LESS;
				3'b011: alu_op = OP_ULESS;
				3'b100: alu_op = OP_XOR;
				3'b101: alu_op = funct7_5 ? OP_SRA : OP_SRL;
				3'b110: alu_op = OP_OR;
				3'b111: alu_op = OP_AND;
			endcase
		end
	end

	alu u_alu (
		.loperand (loperand),
		.roperand (roperand),
		.alu_op   (alu_op),
		.alu_val  (alu_val)
	);

	branch_cmp u_branch_cmp (
		.src1         (src1),
		.src2         (src2),
		.funct3       (funct3),
		.branch_taken (branch_taken)
	);

	assign jump_en = opc[INST_JAL] | opc[INST_JALR] | (opc[INST_BEQ] & branch_taken);

	// trap redirect beats the alu target
	assign jump_addr = csr_jump_en ? csr_jump :
		jump_en ? alu_val : snpc;

	assign csr_imm    = imm.csr.csr_addr;
	assign csr_enable = opc[INST_CSR] & (funct3 != 3'b000);

	assign val = (opc[INST_JAL] | opc[INST_JALR]) ? snpc :
		csr_enable ? csr_val : alu_val;

	assign csr_wdata = (funct3 == F3_CSRRW) ? src1 :
		(funct3 == F3_CSRRS) ? (src1 | csr_val) : '0;

	assign lsu_data = src2;
	assign lsu_ren  = opc[INST_LW];
	assign lsu_wen  = opc[INST_SW];

	a_lsu_hold: assert property (@(posedge clock) disable iff (!rst_n)
		lsu_valid && !lsu_ready |=> lsu_valid)
		else $error("lsu_valid dropped before lsu_ready");

	a_ready_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(exu_ready && lsu_valid))
		else $error("exu_ready high while lsu_valid pending");

	a_complete_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		exu_complete |=> !exu_complete)
		else $error("exu_complete held two cycles");

endmodule

`default_nettype wire

// File: design/csr_unit.sv
`default_nettype none

module csr_unit
	import rv_isa_pkg::*;
(
	input  logic            clock,
	input  logic            rst_n,
	input  logic            exu_complete,
	input  logic            csr_enable,
	input  logic            inst_ecall,
	input  logic            inst_mret,
	input  logic [11:0]     csr_imm,
	input  logic [XLEN-1:0] csr_wdata,
	input  logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] csr_val,
	output logic            csr_jump_en,
	output logic [XLEN-1:0] csr_jump
);

	logic [XLEN-1:0] mstatus;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (exu_complete) begin
			if (csr_enable) begin
				case (csr_imm)
					CSR_MSTATUS: mstatus <= csr_wdata;
					CSR_MTVEC:   mtvec   <= csr_wdata;
					CSR_MEPC:    mepc    <= csr_wdata;
					CSR_MCAUSE:  mcause  <= csr_wdata;
					default: ; // unimplemented csr, write dropped
				endcase
			end else if (inst_ecall) begin
				mepc   <= pc;
				mcause <= MCAUSE_ECALL_M;
			end
			// mret only redirects
		end
	end

	always_comb begin
		case (csr_imm)
			CSR_MSTATUS: csr_val = mstatus;
			CSR_MTVEC:   csr_val = mtvec;
			CSR_MEPC:    csr_val = mepc;
			CSR_MCAUSE:  csr_val = mcause;
			default:     csr_val = '0;
		endcase
	end

	assign csr_jump_en = inst_ecall | inst_mret;
	assign csr_jump    = inst_ecall ? mtvec : mepc;

	a_trap_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(inst_ecall && inst_mret))
		else $error("ecall and mret latched together");

endmodule

`default_nettype wire

// File: design/exu_top.sv
`default_nettype none

module exu_top
	import rv_isa_pkg::*;
(
	input  logic             clock,
	input  logic             rst_n,

	input  logic             exu_valid,
	output logic             exu_ready,
	output logic             lsu_valid,
	input  logic             lsu_ready,

	input  logic [OPC_W-1:0] opcode_type,
	input  logic [3:0]       rd_in,
	input  logic [XLEN-1:0]  src1_in,
	input  logic [XLEN-1:0]  src2_in,
	input  logic [XLEN-1:0]  imm_in,
	input  logic [2:0]       funct3_in,
	input  logic             funct7_5_in,
	input  logic [XLEN-1:0]  pc_in,
	input  logic             reg_wen_in,
	input  logic             inst_ecall_in,
	input  logic             inst_mret_in,

	output logic [XLEN-1:0]  pc,
	output logic [3:0]       rd,
	output logic [2:0]       funct3,
	output logic             reg_wen,
	output logic             exu_complete,
	output logic             jump_wrong,
	output logic [XLEN-1:0]  val,
	output logic [XLEN-1:0]  lsu_data,
	output logic [XLEN-1:0]  jump_addr,
	output logic [XLEN-1:0]  csr_wdata,
	output logic             lsu_ren,
	output logic             lsu_wen
);

	// stage to csr unit
	logic            inst_ecall;
	logic            inst_mret;
	logic            csr_enable;
	logic [11:0]     csr_imm;
	logic [XLEN-1:0] csr_val;
	logic [XLEN-1:0] csr_jump;
	logic            csr_jump_en;

	exu_stage u_exu_stage (
		.clock         (clock),
		.rst_n         (rst_n),
		.exu_valid     (exu_valid),
		.exu_ready     (exu_ready),
		.lsu_valid     (lsu_valid),
		.lsu_ready     (lsu_ready),
		.opcode_type   (opcode_type),
		.rd_in         (rd_in),
		.src1_in       (src1_in),
		.src2_in       (src2_in),
		.imm_in        (imm_in),
		.funct3_in     (funct3_in),
		.funct7_5_in   (funct7_5_in),
		.pc_in         (pc_in),
		.reg_wen_in    (reg_wen_in),
		.inst_ecall_in (inst_ecall_in),
		.inst_mret_in  (inst_mret_in),
		.pc            (pc),
		.rd            (rd),
		.funct3        (funct3),
		.reg_wen       (reg_wen),
		.inst_ecall    (inst_ecall),
		.inst_mret     (inst_mret),
		.exu_complete  (exu_complete),
		.jump_wrong    (jump_wrong),
		.val           (val),
		.lsu_data      (lsu_data),
		.jump_addr     (jump_addr),
		.csr_wdata     (csr_wdata),
		.csr_imm       (csr_imm),
		.lsu_ren       (lsu_ren),
		.lsu_wen       (lsu_wen),
		.csr_enable    (csr_enable),
		.csr_val       (csr_val),
		.csr_jump      (csr_jump),
		.csr_jump_en   (csr_jump_en)
	);

	csr_unit u_csr_unit (
		.clock        (clock),
		.rst_n        (rst_n),
		.exu_complete (exu_complete),
		.csr_enable   (csr_enable),
		.inst_ecall   (inst_ecall),
		.inst_mret    (inst_mret),
		.csr_imm      (csr_imm),
		.csr_wdata    (csr_wdata),
		.pc           (pc),
		.csr_val      (csr_val),
		.csr_jump_en  (csr_jump_en),
		.csr_jump     (csr_jump)
	);

endmodule

`default_nettype wire

// File: verif/tb_exu_top.sv
`default_nettype none

module tb_exu_top
	import rv_isa_pkg::*;
();

	localparam int N_DIRECTED   = 8;
	localparam int N_RANDOM     = 300;
	localparam int N_TOTAL      = N_DIRECTED + N_RANDOM;
	localparam int RESET_CYCLES = 8;
	localparam int LIMIT_CYCLES = RESET_CYCLES + 40 * N_TOTAL;

	logic             clock;
	logic             rst_n;
	logic             exu_valid;
	logic             exu_ready;
	logic             lsu_valid;
	logic             lsu_ready;
	logic [OPC_W-1:0] opcode_type;
	logic [3:0]       rd_in;
	logic [XLEN-1:0]  src1_in;
	logic [XLEN-1:0]  src2_in;
	logic [XLEN-1:0]  imm_in;
	logic [2:0]       funct3_in;
	logic             funct7_5_in;
	logic [XLEN-1:0]  pc_in;
	logic             reg_wen_in;
	logic             inst_ecall_in;
	logic             inst_mret_in;
	logic [XLEN-1:0]  pc;
	logic [3:0]       rd;
	logic [2:0]       funct3;
	logic             reg_wen;
	logic             exu_complete;
	logic             jump_wrong;
	logic [XLEN-1:0]  val;
	logic [XLEN-1:0]  lsu_data;
	logic [XLEN-1:0]  jump_addr;
	logic [XLEN-1:0]  csr_wdata;
	logic             lsu_ren;
	logic             lsu_wen;

	// expected results of the instruction in flight
	logic [XLEN-1:0] exp_val;
	logic [XLEN-1:0] exp_jaddr;
	logic [XLEN-1:0] exp_wdata;
	logic [XLEN-1:0] exp_data;
	logic [41:0]     exp_ctrl; // pc, rd, funct3, reg_wen, lsu_ren, lsu_wen
	logic            exp_jw;
	logic            exp_csr_en;
	logic [XLEN-1:0] csr_sh [4]; // mstatus, mtvec, mepc, mcause
	logic [31:0]     lcg_state;
	int value_errs = 0;
	int proto_errs = 0;
	int n_sent     = 0;
	int n_accept   = 0;
	int n_complete = 0;
	int n_xfer     = 0;

	exu_top u_dut (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [2:0] csr_index(input logic [11:0] addr);
		case (addr)
			CSR_MSTATUS: return 3'd0;
			CSR_MTVEC:   return 3'd1;
			CSR_MEPC:    return 3'd2;
			CSR_MCAUSE:  return 3'd3;
			default:     return 3'd4; // unknown, reads zero
		endcase
	endfunction

	function automatic logic [11:0] pick_csr(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd1: return CSR_MSTATUS;
			3'd2:       return CSR_MTVEC;
			3'd3, 3'd4: return CSR_MEPC;
			3'd5, 3'd6: return CSR_MCAUSE;
			default:    return 12'h7c0;
		endcase
	endfunction

	// random upper bits, csr address in the low twelve
	function automatic logic [XLEN-1:0] csr_imm_word(input logic [11:0] addr);
		imm_word_u w;
		w.word = lcg_next();
		w.csr.csr_addr = addr;
		return w.word;
	endfunction

	function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic f7,
		input logic sub, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (f3)
			3'd0:    return sub ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return f7 ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			3'd7:    return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// expected outputs from the driven inputs, then the shadow csr update
	function automatic void predict(input int cls);
		logic [2:0]      idx;
		logic [XLEN-1:0] old;
		logic [XLEN-1:0] snpc;
		logic            csr_en;
		idx    = csr_index(imm_in[11:0]);
		old    = idx[2] ? '0 : csr_sh[idx[1:0]];
		snpc   = pc_in + 32'd4;
		csr_en = (cls == INST_CSR) && (funct3_in != 3'd0);
		case (cls)
			INST_LUI:             exp_val = imm_in;
			INST_AUIPC, INST_BEQ: exp_val = pc_in + imm_in;
			INST_JAL, INST_JALR:  exp_val = snpc;
			INST_ADDI: exp_val = alu_model(funct3_in, funct7_5_in, 1'b0, src1_in, imm_in);
			INST_ADD:  exp_val = alu_model(funct3_in, funct7_5_in, funct7_5_in, src1_in, src2_in);
			INST_CSR:  exp_val = csr_en ? old : src1_in + imm_in;
			default:   exp_val = src1_in + imm_in; // load or store address
		endcase
		if (inst_ecall_in)
			exp_jaddr = csr_sh[1];
		else if (inst_mret_in)
			exp_jaddr = csr_sh[2];
		else if (cls == INST_JAL || (cls == INST_BEQ && branch_model(funct3_in, src1_in, src2_in)))
			exp_jaddr = pc_in + imm_in;
		else if (cls == INST_JALR)
			exp_jaddr = src1_in + imm_in;
		else
			exp_jaddr = snpc;
		exp_jw     = exp_jaddr != snpc;
		exp_wdata  = (funct3_in == F3_CSRRW) ? src1_in :
			(funct3_in == F3_CSRRS) ? (src1_in | old) : '0;
		exp_data   = src2_in;
		exp_csr_en = csr_en;
		exp_ctrl   = {pc_in, rd_in, funct3_in, reg_wen_in, cls == INST_LW, cls == INST_SW};
		if (csr_en && !idx[2]) begin
			csr_sh[idx[1:0]] = exp_wdata;
		end else if (!csr_en && inst_ecall_in) begin
			csr_sh[2] = pc_in;
			csr_sh[3] = MCAUSE_ECALL_M;
		end
	endfunction

	task automatic send(input int cls, input logic [2:0] f3, input logic [XLEN-1:0] s1,
		input logic [XLEN-1:0] imm, input logic ecall, input logic mret);
		logic [31:0] r;
		logic [31:0] r2;
		do begin
			@(negedge clock);
			exu_valid = 1'b0;
			r = lcg_next();
			lsu_ready = r[31];
		end while (!exu_ready);
		r  = lcg_next();
		r2 = lcg_next();
		opcode_type   = 10'b1 << cls;
		funct3_in     = f3;
		src1_in       = s1;
		src2_in       = (cls == INST_BEQ && r2[31:30] == 2'b00) ? s1 : lcg_next(); // some equal
		imm_in        = imm;
		pc_in         = {r[31:2], 2'b00};
		rd_in         = r2[27:24];
		reg_wen_in    = r2[23];
		funct7_5_in   = r2[22];
		inst_ecall_in = ecall;
		inst_mret_in  = mret;
		predict(cls);
		exu_valid = 1'b1;
		n_sent++;
	endtask

	always @(posedge clock) begin
		if (rst_n) begin
			if (exu_valid && exu_ready)
				n_accept <= n_accept + 1;
			if (exu_complete)
				n_complete <= n_complete + 1;
			if (lsu_valid && lsu_ready)
				n_xfer <= n_xfer + 1;
		end
	end

	a_val: assert property (@(posedge clock) disable iff (!rst_n)
		exu_complete |-> val == exp_val)
		else begin
			value_errs = value_errs + 1;
			$display("ERR %0t: val %h, expected %h", $time, val, exp_val);
		end

	a_jaddr: assert property (@(posedge clock) disable iff (!rst_n)
		exu_complete |-> jump_addr == exp_jaddr)
		else begin
			value_errs = value_errs + 1;
			$display("ERR %0t: jump_addr %h, expected %h", $time, jump_addr, exp_jaddr);
		end

	a_wdata: assert property (@(posedge clock) disable iff (!rst_n)
		exu_complete |-> csr_wdata == exp_wdata && lsu_data == exp_data)
		else begin
			value_errs = value_errs + 1;
			$display("ERR %0t: csr_wdata %h lsu_data %h, expected %h %h", $time,
				csr_wdata, lsu_data, exp_wdata, exp_data);
		end

	a_ctrl: assert property (@(posedge clock) disable iff (!rst_n)
		exu_complete |-> {pc, rd, funct3, reg_wen, lsu_ren, lsu_wen} == exp_ctrl)
		else begin
			value_errs = value_errs + 1;
			$display("ERR %0t: control fields %h, expected %h", $time,
				{pc, rd, funct3, reg_wen, lsu_ren, lsu_wen}, exp_ctrl);
		end

	// one cycle after a redirecting completion, never otherwise
	a_jw: assert property (@(posedge clock) disable iff (!rst_n)
		jump_wrong == ($past(exu_complete) && $past(exp_jw)))
		else begin
			value_errs = value_errs + 1;
			$display("ERR %0t: jump_wrong %b, expected %b", $time, jump_wrong, !jump_wrong);
		end

	a_reset: assert property (@(posedge clock)
		$rose(rst_n) |-> exu_ready && !lsu_valid && !exu_complete && !jump_wrong)
		else begin
			proto_errs = proto_errs + 1;
			$display("control outputs were not idle after reset at time %0t", $time);
		end

	a_accept: assert property (@(posedge clock) disable iff (!rst_n)
		exu_valid && exu_ready |=> exu_complete && lsu_valid)
		else begin
			proto_errs = proto_errs + 1;
			$display("accept at time %0t gave no exu_complete and lsu_valid", $time);
		end

	a_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(exu_ready && lsu_valid))
		else begin
			proto_errs = proto_errs + 1;
			$display("exu_ready was high with lsu_valid at time %0t", $time);
		end

	// csr results may move after the write edge
	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		lsu_valid && !lsu_ready |=> lsu_valid && jump_addr == $past(jump_addr) &&
			lsu_data == $past(lsu_data) && (exp_csr_en || val == $past(val)))
		else begin
			proto_errs = proto_errs + 1;
			$display("lsu_valid or a result changed while lsu_ready was low at time %0t", $time);
		end

	initial begin
		logic [31:0] r;
		int          cls;
		logic        counts_ok;
		clock         = 1'b0;
		rst_n         = 1'b0;
		exu_valid     = 1'b0;
		lsu_ready     = 1'b0;
		opcode_type   = '0;
		rd_in         = '0;
		src1_in       = '0;
		src2_in       = '0;
		imm_in        = '0;
		funct3_in     = '0;
		funct7_5_in   = 1'b0;
		pc_in         = '0;
		reg_wen_in    = 1'b0;
		inst_ecall_in = 1'b0;
		inst_mret_in  = 1'b0;
		exp_jw        = 1'b0;
		exp_csr_en    = 1'b0;
		csr_sh        = '{default: '0};
		lcg_state     = 32'h485776df;
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;

		// csr writes, then trap and return
		send(INST_CSR, F3_CSRRW, 32'h0000_8000, csr_imm_word(CSR_MTVEC), 1'b0, 1'b0);
		send(INST_CSR, F3_CSRRS, 32'h0, csr_imm_word(CSR_MTVEC), 1'b0, 1'b0);
		send(INST_CSR, F3_CSRRW, 32'h0000_1888, csr_imm_word(CSR_MSTATUS), 1'b0, 1'b0);
		send(INST_CSR, 3'd0, 32'h0, 32'h0, 1'b1, 1'b0); // ecall to mtvec
		send(INST_CSR, F3_CSRRS, 32'h0, csr_imm_word(CSR_MEPC), 1'b0, 1'b0);
		send(INST_CSR, F3_CSRRS, 32'h0, csr_imm_word(CSR_MCAUSE), 1'b0, 1'b0);
		send(INST_CSR, F3_CSRRW, 32'h0000_2000, csr_imm_word(CSR_MEPC), 1'b0, 1'b0);
		send(INST_CSR, 3'd0, 32'h0, 32'h0, 1'b0, 1'b1); // mret

		for (int i = 0; i < N_RANDOM; i++) begin
			r   = lcg_next();
			cls = int'((r >> 8) % 32'd10);
			if (cls == INST_CSR)
				send(cls, r[30:28], lcg_next(), csr_imm_word(pick_csr(r[26:24])), 1'b0, 1'b0);
			else
				send(cls, r[30:28], lcg_next(), lcg_next(), 1'b0, 1'b0);
		end

		do begin
			@(negedge clock);
			exu_valid = 1'b0;
			lsu_ready = 1'b1;
		end while (lsu_valid || !exu_ready);

		counts_ok = (n_accept == N_TOTAL) && (n_complete == N_TOTAL) && (n_xfer == N_TOTAL);
		if (!counts_ok)
			$display("handshake counts differ: %0d sent, %0d accepted, %0d completed, %0d moved on",
				n_sent, n_accept, n_complete, n_xfer);
		$display("errors: %0d value, %0d protocol, handshake counts %s, %0d instructions",
			value_errs, proto_errs, counts_ok ? "ok" : "wrong", n_sent);
		if (value_errs == 0 && proto_errs == 0 && counts_ok)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		#(LIMIT_CYCLES * 10);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
design/rv_isa_pkg.sv
design/exu_op_pkg.sv
design/alu.sv
design/branch_cmp.sv
design/exu_stage.sv
design/csr_unit.sv
design/exu_top.sv
verif/tb_exu_top.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_exu_top \
	--Mdir obj_dir -o sim_tb_exu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_exu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
